//--- hw/frontend_pkg.sv
package frontend_pkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------

	// Byte address width on the fetch bus
	localparam int W_ADDR = 32;
	// Fetch bus data width
	// Assembly assumes exactly two parcels per word
	localparam int W_DATA = 32;
	// One compressed parcel
	localparam int W_HALF = 16;

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------

	// One 16-bit instruction parcel
	typedef logic [W_HALF-1:0] half_t;

	// Parcel pair, upper parcel first so it lines up with bit order
	typedef struct packed {
		half_t hi;
		half_t lo;
	} half_pair_t;

	// Current instruction register
	// Whole word for a 32-bit instruction, lo alone for a 16-bit one
	typedef union packed {
		logic [31:0] word;
		half_pair_t  half;
	} cir_t;

	// Fetched bus word, stored whole and split into parcels by assembly
	typedef union packed {
		logic [W_DATA-1:0] word;
		half_pair_t        half;
	} fetch_word_t;

	// Halfword count for CIR valid, decode request and yard level
	typedef logic [1:0] hw_count_t;

endpackage

//--- hw/queue_ctrl_if.sv
`timescale 1ns/1ps

interface queue_ctrl_if;

	// Jump accepted this cycle
	// Queue read side is emptied
	logic jump_taken;
	// Stale fetches still outstanding, incoming bus data is thrown away
	logic drop;
	// Next kept word begins at its upper parcel
	logic unaligned_dph;

	// Queue occupancy, used for fetch throttling
	logic full;
	logic almost_full;

	// Fetch control side
	modport ctrl (
		output jump_taken,
		output drop,
		output unaligned_dph,
		input  full,
		input  almost_full
	);

	// Queue side
	modport queue (
		input  jump_taken,
		input  drop,
		input  unaligned_dph,
		output full,
		output almost_full
	);

endinterface

//--- hw/fetch_stream_if.sv
`timescale 1ns/1ps

interface fetch_stream_if import frontend_pkg::*; ();

	// Word on offer, either queue head or bypassed bus data
	fetch_word_t word;
	logic        vld;
	// Jump or drop in progress
	// Assembly empties its yard
	logic        flush;
	// Only the upper parcel of word belongs to the new stream
	logic        unaligned;

	// Assembly has room for two parcels
	// Transfer happens when vld and take are both high
	logic        take;

	// Queue side
	modport src (
		output word,
		output vld,
		output flush,
		output unaligned,
		input  take
	);

	// Assembly side
	modport dst (
		input  word,
		input  vld,
		input  flush,
		input  unaligned,
		output take
	);

endinterface

//--- hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import frontend_pkg::*; #(
	parameter int FIFO_DEPTH = 2
) (
	input  logic              clk,
	input  logic              rst_n,

	// Bus address phase plus data-phase completion for counting
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_size,
	output logic              mem_addr_vld,
	input  logic              mem_addr_rdy,
	input  logic              mem_data_vld,

	// Jump request from the core
	input  logic [W_ADDR-1:0] jump_target,
	input  logic              jump_target_vld,
	output logic              jump_target_rdy,

	queue_ctrl_if.ctrl        q
);

	// Outstanding fetch limit
	// A single-word queue can absorb only one fetch in flight
	localparam logic [1:0] MAX_PENDING = (FIFO_DEPTH > 1) ? 2'd2 : 2'd1;

	logic              addr_hold;
	logic [1:0]        pending_fetches;
	logic [1:0]        pending_next;
	logic [1:0]        flush_pending;
	logic [W_ADDR-1:0] fetch_addr;
	logic              addr_accept;
	logic              jump_now;
	logic              unaligned_now;
	logic              unaligned_aph;
	logic              unaligned_dph;
	logic              fetch_stall;

	assign addr_accept     = mem_addr_vld && mem_addr_rdy;
	// Jumps wait while the bus is holding an address
	assign jump_target_rdy = !addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign unaligned_now   = jump_now && jump_target[1];
	assign pending_next    = pending_fetches + {1'b0, addr_accept} - {1'b0, mem_data_vld};

	// ------------------------------------------------------------------------
	// Bus state tracking
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold       <= 1'b0;
			pending_fetches <= 2'd0;
			flush_pending   <= 2'd0;
		end else begin
			// Address must stay put until the bus takes it
			addr_hold       <= mem_addr_vld && !mem_addr_rdy;
			pending_fetches <= pending_next;
			if (jump_now) begin
				// All fetches already out are stale
				// The jump fetch itself is never in this count
				flush_pending <= pending_fetches - {1'b0, mem_data_vld};
			end else if (flush_pending != 2'd0 && mem_data_vld) begin
				flush_pending <= flush_pending - 2'd1;
			end
		end
	end

	// Fetch address runs ahead of decode in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= '0;
		end else if (jump_now) begin
			// Step past the target only if it went out this cycle
			fetch_addr <= {jump_target[W_ADDR-1:2], 2'b00}
				+ (mem_addr_rdy ? W_ADDR'(4) : W_ADDR'(0));
		end else if (addr_accept) begin
			fetch_addr <= fetch_addr + W_ADDR'(4);
		end
	end

	// ------------------------------------------------------------------------
	// Unaligned jump tracking
	// ------------------------------------------------------------------------

	// aph marks a held address that still needs the halfword offset
	// dph marks a first kept word that must be loaded from its upper parcel
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unaligned_aph <= 1'b0;
			unaligned_dph <= 1'b0;
		end else begin
			if (mem_addr_rdy) begin
				unaligned_aph <= 1'b0;
			end
			if (mem_data_vld && flush_pending == 2'd0) begin
				unaligned_dph <= 1'b0;
			end
			// New jump wins over the clears above
			// Its own target decides both flags, aligned or not
			if (jump_now) begin
				unaligned_dph <= jump_target[1];
				unaligned_aph <= jump_target[1] && !mem_addr_rdy;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Address phase request
	// ------------------------------------------------------------------------

	// Built from registered counts so bus ready has no path into the request
	assign fetch_stall = q.full
		|| (q.almost_full && pending_fetches != 2'd0)
		|| pending_fetches >= MAX_PENDING;

	// Priority is held address, then jump, then next word
	always_comb begin
		mem_addr     = fetch_addr;
		mem_size     = 1'b1;
		mem_addr_vld = 1'b1;
		if (addr_hold) begin
			mem_addr = {fetch_addr[W_ADDR-1:2], unaligned_aph, 1'b0};
			mem_size = !unaligned_aph;
		end else if (jump_target_vld) begin
			// Halfword access for a target in the upper parcel
			mem_addr = {jump_target[W_ADDR-1:1], 1'b0};
			mem_size = !unaligned_now;
		end else if (fetch_stall) begin
			mem_addr_vld = 1'b0;
		end
	end

	assign q.jump_taken    = jump_now;
	assign q.drop          = flush_pending != 2'd0;
	assign q.unaligned_dph = unaligned_dph;

	// Stale fetches are a subset of the fetches in flight
	a_flush_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		flush_pending <= pending_fetches)
		else $error("flush count exceeds pending fetches");

endmodule

//--- hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import frontend_pkg::*; #(
	parameter int FIFO_DEPTH = 2
) (
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_word_t mem_data,
	input  logic        mem_data_vld,
	queue_ctrl_if.queue q,
	fetch_stream_if.src s
);

	// Extra pointer bit tells full from empty
	localparam int W_PTR = $clog2(FIFO_DEPTH) + 1;
	// Slot index width, one bit even for a single slot
	localparam int W_IDX = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	fetch_word_t      mem [FIFO_DEPTH];
	logic [W_PTR-1:0] wptr;
	logic [W_PTR-1:0] rptr;
	logic [W_IDX-1:0] widx;
	logic [W_IDX-1:0] ridx;
	logic [W_PTR-1:0] level;
	logic             empty;
	logic             keep;
	logic             push;
	logic             pop;

	// Storage slot from pointer with the depth a power of two
	assign widx  = W_IDX'(wptr & W_PTR'(FIFO_DEPTH - 1));
	assign ridx  = W_IDX'(rptr & W_PTR'(FIFO_DEPTH - 1));
	assign level = wptr - rptr;
	assign empty = level == '0;

	assign q.full        = level == W_PTR'(FIFO_DEPTH);
	assign q.almost_full = level == W_PTR'(FIFO_DEPTH - 1);

	// ------------------------------------------------------------------------
	// Stream side
	// ------------------------------------------------------------------------

	assign s.flush     = q.jump_taken || q.drop;
	assign s.unaligned = q.unaligned_dph;

	// Beat from the old stream, or one landing in a jump cycle, is lost
	assign keep = mem_data_vld && !s.flush;

	// Empty queue passes the bus beat straight through
	assign s.word = empty ? mem_data : mem[ridx];
	assign s.vld  = !s.flush && (!empty || keep);

	// Beat is stored only when nobody takes it right away
	assign push = keep && !(empty && s.take);
	assign pop  = !empty && s.vld && s.take;

	// ------------------------------------------------------------------------
	// Pointers and storage
	// ------------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			// Jump discards everything between the pointers
			if (q.jump_taken) begin
				rptr <= wptr;
			end else if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[widx] <= mem_data;
		end
	end

	// Fetch throttling must leave a slot for every beat in flight
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		!(push && q.full))
		else $error("fetch queue overflow");

	// Untaken word stays on offer until taken or flushed
	a_word_held: assert property (@(posedge clk) disable iff (!rst_n)
		s.vld && !s.take |=> s.flush || (s.vld && $stable(s.word)))
		else $error("fetch stream word lost while stalled");

endmodule

//--- hw/instr_assembly.sv
`timescale 1ns/1ps

module instr_assembly import frontend_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	fetch_stream_if.dst s,
	output cir_t        cir,
	output hw_count_t   cir_vld,
	input  hw_count_t   cir_req
);

	// Yard is {hwbuf, cir.hi, cir.lo}, filled from lo upward
	// buf_level counts valid parcels in it, 0 to 3
	hw_count_t buf_level;
	hw_count_t consumption;
	hw_count_t level_after;
	hw_count_t level_next;
	half_t     hwbuf;
	half_t     yard [3];
	logic      xfer;

	// Decode never frees more than it holds
	assign consumption = (cir_req <= cir_vld) ? cir_req : cir_vld;
	assign level_after = buf_level - consumption;

	// Room for a whole word once decode has taken its share
	assign s.take = level_after <= 2'd1;
	assign xfer   = s.vld && s.take;

	// ------------------------------------------------------------------------
	// Level update
	// ------------------------------------------------------------------------

	always_comb begin
		if (s.flush) begin
			level_next = '0;
		end else if (xfer && s.unaligned) begin
			// Only the upper parcel is from the jump target
			level_next = level_after + 2'd1;
		end else if (xfer) begin
			level_next = level_after + 2'd2;
		end else begin
			level_next = level_after;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= '0;
			cir_vld   <= '0;
		end else begin
			buf_level <= level_next;
			// Third parcel sits in hwbuf, CIR shows at most two
			cir_vld   <= (level_next > 2'd2) ? 2'd2 : level_next;
		end
	end

	// ------------------------------------------------------------------------
	// Parcel movement
	// ------------------------------------------------------------------------

	// Shift out consumed parcels, then backfill above what remains
	//   1 consumed: hi drops to lo, hwbuf to hi
	//   2 consumed: hwbuf drops to lo
	//   unaligned:  upper fetch parcel alone lands at the fill point
	always_comb begin
		yard[0] = cir.half.lo;
		yard[1] = cir.half.hi;
		yard[2] = hwbuf;
		if (consumption == 2'd1) begin
			yard[0] = cir.half.hi;
			yard[1] = hwbuf;
		end else if (consumption == 2'd2) begin
			yard[0] = hwbuf;
		end
		// take guarantees the fill point is 0 or 1
		if (xfer) begin
			if (s.unaligned) begin
				yard[level_after] = s.word.half.hi;
			end else begin
				yard[level_after]        = s.word.half.lo;
				yard[level_after + 2'd1] = s.word.half.hi;
			end
		end
	end

	// Parcel contents are qualified by the level
	always_ff @(posedge clk) begin
		cir.half.lo <= yard[0];
		cir.half.hi <= yard[1];
		hwbuf       <= yard[2];
	end

	// Decode request protocol
	a_req_range: assert property (@(posedge clk) disable iff (!rst_n)
		cir_req <= 2'd2)
		else $error("cir_req above two halfwords");

	a_req_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(cir_vld == 2'd0 && cir_req == 2'd1))
		else $error("cir_req of one with empty CIR");

endmodule

//--- hw/frontend.sv
`timescale 1ns/1ps

module frontend import frontend_pkg::*; #(
	// Queue depth in words, power of two
	parameter int FIFO_DEPTH = 2
) (
	input  logic              clk,
	input  logic              rst_n,

	// Fetch bus, AHB-lite style address and data phases
	output logic [W_ADDR-1:0] mem_addr,
	output logic              mem_size,
	output logic              mem_addr_vld,
	input  logic              mem_addr_rdy,
	input  logic [W_DATA-1:0] mem_data,
	input  logic              mem_data_vld,

	// Jump request
	input  logic [W_ADDR-1:0] jump_target,
	input  logic              jump_target_vld,
	output logic              jump_target_rdy,

	// Decode side
	output cir_t              cir,
	output hw_count_t         cir_vld,
	input  hw_count_t         cir_req
);

	queue_ctrl_if   qc ();
	fetch_stream_if fs ();

	// ------------------------------------------------------------------------
	// Address generation and flush bookkeeping
	// ------------------------------------------------------------------------

	fetch_ctrl #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fetch_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.q               (qc.ctrl)
	);

	// Word buffer between bus and assembly
	fetch_queue #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fetch_queue (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_data     (mem_data),
		.mem_data_vld (mem_data_vld),
		.q            (qc.queue),
		.s            (fs.src)
	);

	// Parcels into CIR
	instr_assembly u_instr_assembly (
		.clk     (clk),
		.rst_n   (rst_n),
		.s       (fs.dst),
		.cir     (cir),
		.cir_vld (cir_vld),
		.cir_req (cir_req)
	);

endmodule

//--- verification/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb import frontend_pkg::*; ();

	logic              clk = 1'b0;
	logic              rst_n;
	logic [W_ADDR-1:0] mem_addr;
	logic              mem_size;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [W_DATA-1:0] mem_data;
	logic              mem_data_vld;
	logic [W_ADDR-1:0] jump_target;
	logic              jump_target_vld;
	logic              jump_target_rdy;
	cir_t              cir;
	hw_count_t         cir_vld;
	hw_count_t         cir_req;

	// Test records from the input file
	logic [W_ADDR-1:0] rec_target [$];
	int                rec_cycles [$];
	int                rec_bus [$];
	int                rec_dec [$];

	// Reference model and bus model state
	logic [31:0]       lcg_state = 32'd6;
	logic [W_ADDR-1:0] pc;
	logic              dph_vld;
	logic [W_ADDR-1:0] dph_addr;
	logic              held;
	logic [W_ADDR-1:0] held_addr;
	logic              held_size;
	logic              expect_empty;
	logic              jump_pending;
	logic [W_ADDR-1:0] jump_addr;
	logic              saw_parcel;
	longint            watchdog_ns = 0;

	always #20 clk = ~clk;

	frontend #(
		.FIFO_DEPTH (2)
	) UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_size        (mem_size),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_req         (cir_req)
	);

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	// LCG draw in the range 0 to 99
	function int unsigned rand_percent();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) % 100;
	endfunction

	// Parcel content is a pure function of its byte address
	function automatic half_t parcel_at(input logic [W_ADDR-1:0] a);
		return a[15:0] ^ 16'hA5C3;
	endfunction

	function automatic logic [W_DATA-1:0] word_at(input logic [W_ADDR-1:0] a);
		fetch_word_t w;
		w.half.lo = parcel_at({a[W_ADDR-1:2], 2'b00});
		w.half.hi = parcel_at({a[W_ADDR-1:2], 2'b10});
		return w.word;
	endfunction

	task automatic check_half(input string name, input half_t got, input half_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input hw_count_t got, input hw_count_t exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input logic [W_ADDR-1:0] got,
		input logic [W_ADDR-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
	endtask

	// One record per line and lines starting with # are skipped
	task automatic read_records();
		int                fd;
		int                c;
		int                b;
		int                d;
		logic [W_ADDR-1:0] t;
		string             line;
		fd = $fopen("verification/frontend_input.txt", "r");
		if (fd == 0)
			abort_run("Could not open the stimulus file verification/frontend_input.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#"
				&& $sscanf(line, "%h %d %d %d", t, c, b, d) == 4) begin
				rec_target.push_back(t);
				rec_cycles.push_back(c);
				rec_bus.push_back(b);
				rec_dec.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------------
	// Drive after the rising edge and check at the falling edge
	// ------------------------------------------------------------------------

	task automatic step_cycle(input int bus_stall, input int dec_stall);
		logic      rdy;
		logic      took_jump;
		hw_count_t req;
		hw_count_t used;
		// Bus ready also completes the data phase in flight
		rdy             = rand_percent() >= bus_stall;
		mem_addr_rdy    = rdy;
		mem_data_vld    = rdy && dph_vld;
		mem_data        = mem_data_vld ? word_at(dph_addr) : '0;
		jump_target_vld = jump_pending;
		jump_target     = jump_addr;
		// Decode frees 1 or 2 parcels and never more than are valid
		req = 2'd0;
		if (cir_vld != 2'd0 && rand_percent() >= dec_stall) begin
			req = (rand_percent() < 50) ? 2'd1 : 2'd2;
			if (req > cir_vld)
				req = cir_vld;
		end
		cir_req = req;
		@(negedge clk);
		if (cir_vld == 2'd3)
			abort_run("cir_vld reported more than two valid halfwords");
		// Jump port stalls only behind a held bus address
		check_bit("jump_target_rdy", jump_target_rdy, !held);
		if (held) begin
			check_bit("mem_addr_vld", mem_addr_vld, 1'b1);
			check_addr("mem_addr", mem_addr, held_addr);
			check_bit("mem_size", mem_size, held_size);
		end else if (jump_target_vld) begin
			// Jump target goes out at once, halfword-size when unaligned
			check_bit("mem_addr_vld", mem_addr_vld, 1'b1);
			check_addr("mem_addr", mem_addr, jump_target);
			check_bit("mem_size", mem_size, !jump_target[1]);
		end
		if (expect_empty)
			check_count("cir_vld", cir_vld, 2'd0);
		if (cir_vld != 2'd0) begin
			check_half("cir.lo", cir.half.lo, parcel_at(pc));
			saw_parcel = 1'b1;
		end
		if (cir_vld == 2'd2)
			check_half("cir.hi", cir.half.hi, parcel_at(pc + 32'd2));
		// Consumed count is the lesser of request and valid
		used      = (cir_req < cir_vld) ? cir_req : cir_vld;
		took_jump = jump_target_vld && jump_target_rdy;
		if (took_jump) begin
			pc           = jump_target;
			jump_pending = 1'b0;
			saw_parcel   = 1'b0;
		end else begin
			pc = pc + 32'(used) * 32'd2;
		end
		expect_empty = took_jump;
		held         = mem_addr_vld && !rdy;
		held_addr    = mem_addr;
		held_size    = mem_size;
		// Accepted address moves into the data phase
		if (rdy) begin
			dph_vld  = mem_addr_vld;
			dph_addr = mem_addr;
		end
		@(posedge clk);
		#2;
	endtask

	// ------------------------------------------------------------------------
	// Main sequence and watchdog
	// ------------------------------------------------------------------------

	initial begin
		int total;
		total           = 16;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_req         = '0;
		pc              = '0;
		dph_vld         = 1'b0;
		dph_addr        = '0;
		held            = 1'b0;
		held_addr       = '0;
		held_size       = 1'b0;
		expect_empty    = 1'b1;
		jump_pending    = 1'b0;
		jump_addr       = '0;
		saw_parcel      = 1'b0;
		read_records();
		foreach (rec_cycles[i])
			total += rec_cycles[i];
		watchdog_ns = longint'(total) * 40 * 4;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		foreach (rec_target[i]) begin
			jump_addr    = rec_target[i];
			jump_pending = 1'b1;
			while (jump_pending)
				step_cycle(rec_bus[i], rec_dec[i]);
			repeat (rec_cycles[i]) step_cycle(rec_bus[i], rec_dec[i]);
			// Long records must have shown the target parcel
			if (rec_cycles[i] >= 20 && !saw_parcel)
				abort_run($sformatf("No parcel arrived within %0d cycles of the jump to %h",
					rec_cycles[i], rec_target[i]));
		end
		$display(">>> PASS");
		$finish;
	end

	initial begin
		wait (watchdog_ns != 0);
		#(watchdog_ns);
		abort_run($sformatf("Watchdog expired after %0d ns, the run hung", watchdog_ns));
	end

endmodule

//--- verification/frontend_input.txt
# One jump per line: jump_target(hex) cycles bus_stall_pct decode_stall_pct
# Halfword-aligned targets end in 2, 6, A or E
00000000 40 0 0
00000102 30 20 30
00001000 4 30 10
0000200A 25 40 40
00000ABC 60 10 50
00000ABE 3 0 0
0000FFF0 50 0 0
12345678 35 50 20
1234567A 35 50 20
7FFFFFFE 40 25 25
FFFFFFF4 45 15 60
00400000 2 60 0
00400002 30 45 0
0000C0DE 28 35 35
00008000 80 0 70
00000006 5 20 20
00000020 30 45 10
00003332 36 30 30
000BEEF0 26 10 0
000BEEF2 24 40 50
00000010 64 0 0
00000012 1 0 0

//--- filelist.f
hw/frontend_pkg.sv
hw/queue_ctrl_if.sv
hw/fetch_stream_if.sv
hw/fetch_ctrl.sv
hw/fetch_queue.sv
hw/instr_assembly.sv
hw/frontend.sv
verification/frontend_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= frontend_tb
RTL_TOP   ?= frontend
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
